// File: shared_ram_top.f
+incdir+.
shared_ram_pkg.sv
wb_port_bridge.sv
ram_slot_mux.sv
shared_ram_top.sv
tb_sram_model.sv
tb_shared_ram.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_shared_ram \
    -f shared_ram_top.f -o tb_shared_ram > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_shared_ram > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Testbench failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "result: no pass message in log"; exit 1; }
echo "result: PASS"

// File: tb_shared_ram.sv
`include "shared_ram_params.svh"

module tb_shared_ram;

    localparam int ack_timeout = 20;
    localparam int num_words   = 8;
    localparam int num_dual    = 12;

    logic clk2x = 1'b0;
    logic rst_n;

    logic                  [`SR_NUM_PORTS-1:0] wb_cyc;
    logic                  [`SR_NUM_PORTS-1:0] wb_stb;
    logic                  [`SR_NUM_PORTS-1:0] wb_we;
    shared_ram_pkg::addr_t [`SR_NUM_PORTS-1:0] wb_adr;
    shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0] wb_dat_w;
    shared_ram_pkg::sel_t  [`SR_NUM_PORTS-1:0] wb_sel;
    shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0] wb_dat_r;
    logic                  [`SR_NUM_PORTS-1:0] wb_ack;

    shared_ram_pkg::addr_t ram_address;
    shared_ram_pkg::data_t ram_data_o;
    shared_ram_pkg::data_t ram_data_i;
    logic                  ram_wr_n;
    logic                  ram_rd_n;
    logic                  ram_ext_ce_n;
    logic [`SR_SEL_W-1:0]  dataenable_n;

    logic [31:0]           lfsr_state = 32'h9db3_e9e4;
    shared_ram_pkg::data_t mirror [512]; // {bank, word index}
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    test_num = 0;
    int                    test_fail_base = 0;
    int                    ack_total0 = 0;
    int                    ack_total1 = 0;

    always #2 clk2x = ~clk2x;

    shared_ram_top dut0 (
        .clk2x        (clk2x),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .ram_address  (ram_address),
        .ram_data_o   (ram_data_o),
        .ram_data_i   (ram_data_i),
        .ram_wr_n     (ram_wr_n),
        .ram_rd_n     (ram_rd_n),
        .ram_ext_ce_n (ram_ext_ce_n),
        .dataenable_n (dataenable_n)
    );

    tb_sram_model u_sram (
        .clk2x        (clk2x),
        .ram_address  (ram_address),
        .ram_data_o   (ram_data_o),
        .ram_data_i   (ram_data_i),
        .ram_wr_n     (ram_wr_n),
        .ram_rd_n     (ram_rd_n),
        .ram_ext_ce_n (ram_ext_ce_n),
        .dataenable_n (dataenable_n)
    );

    always @(posedge clk2x) begin
        if (wb_ack[0]) ack_total0++;
        if (wb_ack[1]) ack_total1++;
    end

    // ##################################################
    // random numbers and expected values
    // ##################################################

    // fibonacci lfsr with taps 32 22 2 1
    function automatic bit lfsr_step();
        bit fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic shared_ram_pkg::addr_t make_addr(input bit ext, input logic [7:0] idx);
        shared_ram_pkg::addr_t a;
        a = '0;
        a[9:2] = idx;
        a[`SR_EXT_SEL_BIT] = ext;
        return a;
    endfunction

    function automatic logic [8:0] mirror_idx(input shared_ram_pkg::addr_t adr);
        return {adr[`SR_EXT_SEL_BIT], adr[9:2]};
    endfunction

    function automatic shared_ram_pkg::data_t fill_word(input bit ext, input logic [7:0] idx);
        return {4'hb, 3'b000, ext, idx, ~idx, idx ^ 8'h3c};
    endfunction

    // only the enabled byte lanes take the new data
    function automatic shared_ram_pkg::data_t merge_bytes(
        input shared_ram_pkg::data_t old_w,
        input shared_ram_pkg::data_t new_w,
        input shared_ram_pkg::sel_t  sel
    );
        shared_ram_pkg::data_t w;
        w = old_w;
        for (int b = 0; b < `SR_SEL_W; b++) begin
            if (sel[b]) w[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return w;
    endfunction

    // ##################################################
    // checking and wishbone master
    // ##################################################

    task automatic check(input bit cond, input string msg);
        if (cond) pass_count++;
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            fail_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (fail_count == test_fail_base) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d failure(s)", test_num, name, fail_count - test_fail_base);
        end
        test_fail_base = fail_count;
    endtask

    task automatic start_req(
        input bit                    port,
        input logic                  we,
        input shared_ram_pkg::addr_t adr,
        input shared_ram_pkg::data_t dat,
        input shared_ram_pkg::sel_t  sel
    );
        wb_cyc[port]   <= 1'b1;
        wb_stb[port]   <= 1'b1;
        wb_we[port]    <= we;
        wb_adr[port]   <= adr;
        wb_dat_w[port] <= dat;
        wb_sel[port]   <= sel;
    endtask

    task automatic end_req(input bit port);
        wb_cyc[port] <= 1'b0;
        wb_stb[port] <= 1'b0;
    endtask

    task automatic bus_access(
        input  bit                    port,
        input  logic                  we,
        input  shared_ram_pkg::addr_t adr,
        input  shared_ram_pkg::data_t dat,
        input  shared_ram_pkg::sel_t  sel,
        output shared_ram_pkg::data_t rdat
    );
        int waited;
        bit got;
        waited = 0;
        got = 1'b0;
        rdat = '0;
        @(posedge clk2x);
        start_req(port, we, adr, dat, sel);
        while (!got && waited < ack_timeout) begin
            @(posedge clk2x);
            waited++;
            got = wb_ack[port];
        end
        end_req(port);
        if (got) begin
            rdat = wb_dat_r[port];
            // 3 to 6 cycles stb to ack plus the drive edge and the edge that sees ack
            check(waited >= 5 && waited <= 8,
                  $sformatf("port %0d ack seen %0d edges after the request", port, waited));
        end else begin
            $display("port %0d got no ack within %0d cycles, request timed out",
                     port, ack_timeout);
            fail_count++;
        end
    endtask

    // both ports start in the same cycle
    task automatic dual_access(
        input  logic                  we,
        input  shared_ram_pkg::addr_t adr0,
        input  shared_ram_pkg::addr_t adr1,
        input  shared_ram_pkg::data_t dat0,
        input  shared_ram_pkg::data_t dat1,
        output shared_ram_pkg::data_t rdat0,
        output shared_ram_pkg::data_t rdat1
    );
        int waited;
        bit got0;
        bit got1;
        waited = 0;
        got0 = 1'b0;
        got1 = 1'b0;
        rdat0 = '0;
        rdat1 = '0;
        @(posedge clk2x);
        start_req(1'b0, we, adr0, dat0, '1);
        start_req(1'b1, we, adr1, dat1, '1);
        while (!(got0 && got1) && waited < ack_timeout) begin
            @(posedge clk2x);
            waited++;
            if (!got0 && wb_ack[0]) begin
                got0 = 1'b1;
                rdat0 = wb_dat_r[0];
                end_req(1'b0);
            end
            if (!got1 && wb_ack[1]) begin
                got1 = 1'b1;
                rdat1 = wb_dat_r[1];
                end_req(1'b1);
            end
        end
        if (!(got0 && got1)) begin
            $display("dual request timed out after %0d cycles, port 0 ack %0b, port 1 ack %0b",
                     ack_timeout, got0, got1);
            fail_count++;
            end_req(1'b0);
            end_req(1'b1);
        end
    endtask

    // ##################################################
    // test sequence
    // ##################################################

    initial begin
        shared_ram_pkg::addr_t adrs [num_words];
        shared_ram_pkg::addr_t a0;
        shared_ram_pkg::addr_t a1;
        shared_ram_pkg::data_t wdat0;
        shared_ram_pkg::data_t wdat1;
        shared_ram_pkg::data_t rdat0;
        shared_ram_pkg::data_t rdat1;
        shared_ram_pkg::sel_t  sel;
        logic [7:0]            idx0;
        int                    acks0;
        int                    acks1;

        rst_n    <= 1'b0;
        wb_cyc   <= '0;
        wb_stb   <= '0;
        wb_we    <= '0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        wb_sel   <= '0;
        for (int i = 0; i < 256; i++) begin
            mirror[{1'b0, 8'(i)}] = fill_word(1'b0, 8'(i));
            mirror[{1'b1, 8'(i)}] = fill_word(1'b1, 8'(i));
        end
        repeat (4) @(posedge clk2x);
        rst_n <= 1'b1;

        @(posedge clk2x);
        check(ram_wr_n && ram_rd_n && ram_ext_ce_n, "sram strobes not idle after reset");
        check(dataenable_n == '1, "byte enables active after reset");
        check(wb_ack == '0, "ack high after reset");
        finish_test("reset state");

        for (int n = 0; n < num_words; n++) begin
            adrs[n] = make_addr(lfsr_step(), 8'(rand_bits(8)));
            wdat0 = rand_bits(32);
            bus_access(1'b0, 1'b1, adrs[n], wdat0, '1, rdat0);
            mirror[mirror_idx(adrs[n])] = wdat0;
        end
        for (int n = 0; n < num_words; n++) begin
            bus_access(1'b0, 1'b0, adrs[n], '0, '1, rdat0);
            check(rdat0 == mirror[mirror_idx(adrs[n])],
                  $sformatf("port 0 read %h at %h", rdat0, adrs[n]));
        end
        finish_test("port 0 full word write and read");

        for (int n = 0; n < num_words; n++) begin
            adrs[n] = make_addr(lfsr_step(), 8'(rand_bits(8)));
            wdat0 = rand_bits(32);
            sel = `SR_SEL_W'(rand_bits(`SR_SEL_W));
            bus_access(1'b1, 1'b1, adrs[n], wdat0, sel, rdat0);
            mirror[mirror_idx(adrs[n])] = merge_bytes(mirror[mirror_idx(adrs[n])], wdat0, sel);
        end
        for (int n = 0; n < num_words; n++) begin
            bus_access(1'b1, 1'b0, adrs[n], '0, '1, rdat0);
            check(rdat0 == mirror[mirror_idx(adrs[n])],
                  $sformatf("port 1 read %h at %h after byte write", rdat0, adrs[n]));
        end
        finish_test("port 1 byte enable write");

        // one edge so the previous test's last ack is already counted
        @(posedge clk2x);
        acks0 = ack_total0;
        acks1 = ack_total1;
        for (int n = 0; n < num_dual; n++) begin
            idx0 = 8'(rand_bits(8));
            a0 = make_addr(lfsr_step(), idx0);
            a1 = make_addr(lfsr_step(), idx0 + 8'd1 + {1'b0, 7'(rand_bits(7))});
            wdat0 = rand_bits(32);
            wdat1 = rand_bits(32);
            dual_access(1'b1, a0, a1, wdat0, wdat1, rdat0, rdat1);
            mirror[mirror_idx(a0)] = wdat0;
            mirror[mirror_idx(a1)] = wdat1;
            dual_access(1'b0, a0, a1, '0, '0, rdat0, rdat1);
            check(rdat0 == mirror[mirror_idx(a0)], $sformatf("port 0 read %h at %h", rdat0, a0));
            check(rdat1 == mirror[mirror_idx(a1)], $sformatf("port 1 read %h at %h", rdat1, a1));
        end
        repeat (4) @(posedge clk2x);
        check(ack_total0 - acks0 == 2 * num_dual,
              $sformatf("port 0 gave %0d acks for %0d requests", ack_total0 - acks0, 2 * num_dual));
        check(ack_total1 - acks1 == 2 * num_dual,
              $sformatf("port 1 gave %0d acks for %0d requests", ack_total1 - acks1, 2 * num_dual));
        finish_test("concurrent ports");

        for (int n = 0; n < 4; n++) begin
            a0 = make_addr(lfsr_step(), 8'(rand_bits(8)));
            wdat0 = rand_bits(32);
            bus_access(1'b0, 1'b1, a0, wdat0, '1, rdat0);
            mirror[mirror_idx(a0)] = wdat0;
            bus_access(1'b1, 1'b0, a0, '0, '1, rdat1);
            check(rdat1 == wdat0, $sformatf("port 1 read %h at %h, port 0 wrote %h",
                                            rdat1, a0, wdat0));
        end
        finish_test("cross port visibility");

        idx0 = 8'(rand_bits(8));
        a0 = make_addr(1'b1, idx0);
        a1 = make_addr(1'b0, idx0);
        wdat0 = rand_bits(32);
        wdat1 = ~wdat0;
        bus_access(1'b0, 1'b1, a0, wdat0, '1, rdat0);
        bus_access(1'b0, 1'b1, a1, wdat1, '1, rdat0);
        mirror[mirror_idx(a0)] = wdat0;
        mirror[mirror_idx(a1)] = wdat1;
        bus_access(1'b1, 1'b0, a0, '0, '1, rdat0);
        bus_access(1'b1, 1'b0, a1, '0, '1, rdat1);
        check(rdat0 == wdat0, $sformatf("external bank read %h, expected %h", rdat0, wdat0));
        check(rdat1 == wdat1, $sformatf("on-board bank read %h, expected %h", rdat1, wdat1));
        finish_test("bank select");

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb_sram_model.sv
`include "shared_ram_params.svh"

module tb_sram_model (
    input  logic                  clk2x,
    input  shared_ram_pkg::addr_t ram_address,
    input  shared_ram_pkg::data_t ram_data_o,
    output shared_ram_pkg::data_t ram_data_i,
    input  logic                  ram_wr_n,
    input  logic                  ram_rd_n,
    input  logic                  ram_ext_ce_n,
    input  logic [`SR_SEL_W-1:0]  dataenable_n
);

    shared_ram_pkg::data_t mem_int [256]; // on-board bank
    shared_ram_pkg::data_t mem_ext [256]; // selected by ram_ext_ce_n low

    logic [7:0] word_idx;

    // power-up contents, a function of bank and word index
    function automatic shared_ram_pkg::data_t fill_word(input logic ext, input logic [7:0] idx);
        return {4'hb, 3'b000, ext, idx, ~idx, idx ^ 8'h3c};
    endfunction

    function automatic shared_ram_pkg::data_t write_lanes(
        input shared_ram_pkg::data_t old_w,
        input shared_ram_pkg::data_t new_w,
        input logic [`SR_SEL_W-1:0]  be_n
    );
        shared_ram_pkg::data_t w;
        w = old_w;
        for (int b = 0; b < `SR_SEL_W; b++) begin
            if (!be_n[b]) begin
                w[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return w;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_int[i] = fill_word(1'b0, 8'(i));
            mem_ext[i] = fill_word(1'b1, 8'(i));
        end
    end

    assign word_idx = ram_address[9:2]; // word address, byte offset dropped

    // asynchronous read
    assign ram_data_i = ram_rd_n ? '0 :
                        (ram_ext_ce_n ? mem_int[word_idx] : mem_ext[word_idx]);

    always @(posedge clk2x) begin
        if (!ram_wr_n) begin
            if (ram_ext_ce_n) begin
                mem_int[word_idx] = write_lanes(mem_int[word_idx], ram_data_o, dataenable_n);
            end else begin
                mem_ext[word_idx] = write_lanes(mem_ext[word_idx], ram_data_o, dataenable_n);
            end
        end
    end

endmodule

// File: shared_ram_top.sv
`include "shared_ram_params.svh"

module shared_ram_top (
    input  logic                                        clk2x,
    input  logic                                        rst_n,

    // wishbone slave ports, indexed by port
    input  logic                  [`SR_NUM_PORTS-1:0]   wb_cyc,
    input  logic                  [`SR_NUM_PORTS-1:0]   wb_stb,
    input  logic                  [`SR_NUM_PORTS-1:0]   wb_we,
    input  shared_ram_pkg::addr_t [`SR_NUM_PORTS-1:0]   wb_adr,
    input  shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0]   wb_dat_w,
    input  shared_ram_pkg::sel_t  [`SR_NUM_PORTS-1:0]   wb_sel,
    output shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0]   wb_dat_r,
    output logic                  [`SR_NUM_PORTS-1:0]   wb_ack,

    // sram pins
    output shared_ram_pkg::addr_t                       ram_address,
    output shared_ram_pkg::data_t                       ram_data_o,
    input  shared_ram_pkg::data_t                       ram_data_i,
    output logic                                        ram_wr_n,
    output logic                                        ram_rd_n,
    output logic                                        ram_ext_ce_n,
    output logic                  [`SR_SEL_W-1:0]       dataenable_n
);

    // bridge to mux, one lane per port
    logic                  [`SR_NUM_PORTS-1:0] req;
    logic                  [`SR_NUM_PORTS-1:0] req_we;
    shared_ram_pkg::addr_t [`SR_NUM_PORTS-1:0] req_adr;
    shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0] req_dat;
    shared_ram_pkg::sel_t  [`SR_NUM_PORTS-1:0] req_sel;
    logic                  [`SR_NUM_PORTS-1:0] done;
    shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0] rsp_dat;

    // ##################################################
    // port bridges
    // ##################################################

    for (genvar i = 0; i < `SR_NUM_PORTS; i++) begin : g_port
        wb_port_bridge u_bridge (
            .clk2x    (clk2x),
            .rst_n    (rst_n),
            .wb_cyc   (wb_cyc[i]),
            .wb_stb   (wb_stb[i]),
            .wb_we    (wb_we[i]),
            .wb_adr   (wb_adr[i]),
            .wb_dat_w (wb_dat_w[i]),
            .wb_sel   (wb_sel[i]),
            .wb_dat_r (wb_dat_r[i]),
            .wb_ack   (wb_ack[i]),
            .req      (req[i]),
            .req_we   (req_we[i]),
            .req_adr  (req_adr[i]),
            .req_dat  (req_dat[i]),
            .req_sel  (req_sel[i]),
            .done     (done[i]),
            .rsp_dat  (rsp_dat[i])
        );
    end

    // ##################################################
    // slot mux
    // ##################################################

    ram_slot_mux u_mux (
        .clk2x        (clk2x),
        .rst_n        (rst_n),
        .req          (req),
        .req_we       (req_we),
        .req_adr      (req_adr),
        .req_dat      (req_dat),
        .req_sel      (req_sel),
        .done         (done),
        .rsp_dat      (rsp_dat),
        .ram_address  (ram_address),
        .ram_data_o   (ram_data_o),
        .ram_data_i   (ram_data_i),
        .ram_wr_n     (ram_wr_n),
        .ram_rd_n     (ram_rd_n),
        .ram_ext_ce_n (ram_ext_ce_n),
        .dataenable_n (dataenable_n)
    );

endmodule

// File: ram_slot_mux.sv
`include "shared_ram_params.svh"

module ram_slot_mux (
    input  logic                                        clk2x,
    input  logic                                        rst_n,

    // per-port requests from the bridges
    input  logic                  [`SR_NUM_PORTS-1:0]   req,
    input  logic                  [`SR_NUM_PORTS-1:0]   req_we,
    input  shared_ram_pkg::addr_t [`SR_NUM_PORTS-1:0]   req_adr,
    input  shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0]   req_dat,
    input  shared_ram_pkg::sel_t  [`SR_NUM_PORTS-1:0]   req_sel,
    output logic                  [`SR_NUM_PORTS-1:0]   done,
    output shared_ram_pkg::data_t [`SR_NUM_PORTS-1:0]   rsp_dat,

    // asynchronous sram pins
    output shared_ram_pkg::addr_t                       ram_address,
    output shared_ram_pkg::data_t                       ram_data_o,
    input  shared_ram_pkg::data_t                       ram_data_i,
    output logic                                        ram_wr_n,
    output logic                                        ram_rd_n,
    output logic                                        ram_ext_ce_n,
    output logic                  [`SR_SEL_W-1:0]       dataenable_n
);

    localparam int port_idx_w = $clog2(`SR_NUM_PORTS);

    shared_ram_pkg::slot_e slot;
    shared_ram_pkg::slot_e slot_next;

    logic                  launch_en;
    logic [port_idx_w-1:0] launch_idx;
    logic                  cap_en;
    logic [port_idx_w-1:0] cap_idx;
    logic                  ram_busy;

    // ##################################################
    // phase ring
    // ##################################################

    always_comb begin
        unique case (slot)
            shared_ram_pkg::slot_p0_launch:  slot_next = shared_ram_pkg::slot_p1_launch;
            shared_ram_pkg::slot_p1_launch:  slot_next = shared_ram_pkg::slot_p1_capture;
            shared_ram_pkg::slot_p1_capture: slot_next = shared_ram_pkg::slot_idle;
            shared_ram_pkg::slot_idle:       slot_next = shared_ram_pkg::slot_p0_launch;
            default:                         slot_next = shared_ram_pkg::slot_p0_launch;
        endcase
    end

    // which port owns the current edge
    assign launch_en  = (slot == shared_ram_pkg::slot_p0_launch) ||
                        (slot == shared_ram_pkg::slot_p1_launch);
    assign launch_idx = port_idx_w'(slot == shared_ram_pkg::slot_p1_launch);

    // capture lags the launch by one phase
    assign cap_en  = (slot == shared_ram_pkg::slot_p1_launch) ||
                     (slot == shared_ram_pkg::slot_p1_capture);
    assign cap_idx = port_idx_w'(slot == shared_ram_pkg::slot_p1_capture);

    // strobes on the pins still belong to the port being captured
    assign ram_busy = ~(ram_rd_n & ram_wr_n);

    // ##################################################
    // sram strobes and done
    // ##################################################

    always_ff @(posedge clk2x or negedge rst_n) begin
        if (!rst_n) begin
            slot         <= shared_ram_pkg::slot_p0_launch;
            ram_wr_n     <= 1'b1;
            ram_rd_n     <= 1'b1;
            ram_ext_ce_n <= 1'b1;
            dataenable_n <= '1;
            done         <= '0;
        end else begin
            slot <= slot_next;

            done <= '0;
            if (cap_en) begin
                done[cap_idx] <= ram_busy;
            end

            if (launch_en && req[launch_idx]) begin
                ram_wr_n     <= ~req_we[launch_idx];
                ram_rd_n     <= req_we[launch_idx];
                ram_ext_ce_n <= ~req_adr[launch_idx][`SR_EXT_SEL_BIT];
                dataenable_n <= ~req_sel[launch_idx];
            end else begin
                // empty slot, or one of the two that launch nothing
                ram_wr_n     <= 1'b1;
                ram_rd_n     <= 1'b1;
                ram_ext_ce_n <= 1'b1;
                dataenable_n <= '1;
            end
        end
    end

    // address, write data and read capture
    always_ff @(posedge clk2x) begin
        if (launch_en) begin
            ram_address <= req_adr[launch_idx];
            ram_data_o  <= req_dat[launch_idx];
        end
        if (cap_en) begin
            rsp_dat[cap_idx] <= ram_data_i;
        end
    end

endmodule

// File: wb_port_bridge.sv
`include "shared_ram_params.svh"

module wb_port_bridge (
    input  logic                  clk2x,
    input  logic                  rst_n,

    // wishbone classic slave
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  shared_ram_pkg::addr_t wb_adr,
    input  shared_ram_pkg::data_t wb_dat_w,
    input  shared_ram_pkg::sel_t  wb_sel,
    output shared_ram_pkg::data_t wb_dat_r,
    output logic                  wb_ack,

    // towards the slot mux
    output logic                  req,
    output logic                  req_we,
    output shared_ram_pkg::addr_t req_adr,
    output shared_ram_pkg::data_t req_dat,
    output shared_ram_pkg::sel_t  req_sel,
    input  logic                  done,
    input  shared_ram_pkg::data_t rsp_dat
);

    shared_ram_pkg::req_e state;

    logic accept;
    logic finish;

    // ##################################################
    // handshake decode
    // ##################################################

    assign accept = (state == shared_ram_pkg::req_idle) && wb_cyc && wb_stb;
    assign finish = (state == shared_ram_pkg::req_wait) && done;

    // held from the cycle after accept until the cycle after done
    assign req = (state == shared_ram_pkg::req_wait);

    // ##################################################
    // request state
    // ##################################################

    always_ff @(posedge clk2x or negedge rst_n) begin
        if (!rst_n) begin
            state  <= shared_ram_pkg::req_idle;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0; // single cycle pulse
            case (state)
                shared_ram_pkg::req_idle: begin
                    if (accept) begin
                        state <= shared_ram_pkg::req_wait;
                    end
                end
                shared_ram_pkg::req_wait: begin
                    if (done) begin
                        state  <= shared_ram_pkg::req_ack;
                        wb_ack <= 1'b1;
                    end
                end
                shared_ram_pkg::req_ack: begin
                    // master drops stb on this edge
                    state <= shared_ram_pkg::req_idle;
                end
                default: begin
                    state <= shared_ram_pkg::req_idle;
                end
            endcase
        end
    end

    // request and response words
    always_ff @(posedge clk2x) begin
        if (accept) begin
            req_we  <= wb_we;
            req_adr <= wb_adr;
            req_dat <= wb_dat_w;
            req_sel <= wb_sel;
        end
        if (finish) begin
            wb_dat_r <= rsp_dat; // don't care on writes
        end
    end

endmodule

// File: shared_ram_pkg.sv
`include "shared_ram_params.svh"

package shared_ram_pkg;

    // vectors with a meaning of their own
    typedef logic [`SR_ADDR_W-1:0] addr_t;
    typedef logic [`SR_DATA_W-1:0] data_t;
    typedef logic [`SR_SEL_W-1:0]  sel_t;  // active high, inverted only at the pins

    // one-hot ring, one step per clk2x cycle
    typedef enum logic [3:0] {
        slot_p0_launch  = 4'b0001,
        slot_p1_launch  = 4'b0010, // also captures port 0
        slot_p1_capture = 4'b0100,
        slot_idle       = 4'b1000
    } slot_e;

    // wishbone side of one port
    typedef enum logic [1:0] {
        req_idle,
        req_wait, // request handed to the slot mux
        req_ack   // ack cycle, keeps a held stb from being taken twice
    } req_e;

endpackage

// File: shared_ram_params.svh
`ifndef SR_PARAMS_SVH
`define SR_PARAMS_SVH

// ##################################################
// bus widths
// ##################################################

`define SR_ADDR_W 32 // byte address from the wishbone side
`define SR_DATA_W 32
`define SR_SEL_W 4   // one enable per byte lane

// ##################################################
// port and slot layout
// ##################################################

// the four-phase ring only has room for two launch slots
`define SR_NUM_PORTS 2

// high selects the external ram through ram_ext_ce_n
`define SR_EXT_SEL_BIT 22

`endif
